// File: csr_pkg.sv
// ########################################
// Package with CSR addresses, identity values, op enum and pipeline structs.
// ########################################

package csr_pkg;

	// Machine trap setup and handling.
	localparam logic [11:0] CSR_MSTATUS = 12'h300;
	localparam logic [11:0] CSR_MIE = 12'h304;
	localparam logic [11:0] CSR_MTVEC = 12'h305;
	localparam logic [11:0] CSR_MSCRATCH = 12'h340;
	localparam logic [11:0] CSR_MEPC = 12'h341;
	localparam logic [11:0] CSR_MCAUSE = 12'h342;
	localparam logic [11:0] CSR_MIP = 12'h344;

	// User counters, low and high halves.
	localparam logic [11:0] CSR_CYCLE = 12'hC00;
	localparam logic [11:0] CSR_TIME = 12'hC01;
	localparam logic [11:0] CSR_INSTRET = 12'hC02;
	localparam logic [11:0] CSR_CYCLEH = 12'hC80;
	localparam logic [11:0] CSR_TIMEH = 12'hC81;
	localparam logic [11:0] CSR_INSTRETH = 12'hC82;

	// Read-only machine identity.
	localparam logic [11:0] CSR_MVENDORID = 12'hF11;
	localparam logic [11:0] CSR_MARCHID = 12'hF12;
	localparam logic [11:0] CSR_MIMPID = 12'hF13;
	localparam logic [11:0] CSR_MHARTID = 12'hF14;

	localparam logic [31:0] VENDOR_ID = 32'h0000_0000;
	localparam logic [31:0] ARCH_ID = 32'h0000_0023;
	localparam logic [31:0] IMP_ID = 32'h0001_0002;
	localparam logic [31:0] HART_ID = 32'h0000_0000;

	// Clocks per wall-time tick, kept small for simulation.
	localparam int TICK_CLOCKS = 8;
	localparam int TICK_WIDTH = $clog2(TICK_CLOCKS);

	// Interrupt causes, top bit marks an interrupt.
	localparam logic [31:0] CAUSE_EXTERNAL = 32'h8000_000B;
	localparam logic [31:0] CAUSE_TIMER = 32'h8000_0007;
	localparam logic [31:0] CAUSE_SOFTWARE = 32'h8000_0003;

	typedef enum logic [2:0] {
		OP_NONE = 3'd0,
		OP_WRITE = 3'd1,
		OP_SET = 3'd2,
		OP_CLEAR = 3'd3,
		OP_ECALL = 3'd4,
		OP_MRET = 3'd5
	} csr_op_t;

	// Decoded request handed to the CSR file.
	typedef struct packed {
		logic valid;
		csr_op_t op;
		logic [11:0] index;
		logic [31:0] operand;
		logic [4:0] rd;
		logic write_en;
	} csr_req_t;

	// Old CSR value returned to the register file.
	typedef struct packed {
		logic valid;
		logic [4:0] rd;
		logic [31:0] rdata;
	} csr_result_t;

	typedef struct packed {
		logic [63:0] cycle;
		logic [63:0] wall_time;
		logic [63:0] instret;
	} csr_counts_t;

endpackage

// File: csr_decode.sv
// ########################################
// SYSTEM instruction decode stage.
// ########################################
`timescale 1ns/100ps

module csr_decode (
	input logic i_clock,
	input logic i_reset,
	input logic i_instr_valid,
	input logic [31:0] i_instr,
	input logic [31:0] i_rs1_value,
	output csr_pkg::csr_req_t o_req
);

	localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;
	localparam logic [31:0] INSTR_ECALL = 32'h0000_0073;
	localparam logic [31:0] INSTR_MRET = 32'h3020_0073;

	logic [2:0] funct3;
	logic [4:0] rs1_field;
	logic is_system;
	csr_pkg::csr_req_t req_next;

	assign funct3 = i_instr[14:12];
	assign rs1_field = i_instr[19:15];
	assign is_system = i_instr_valid && (i_instr[6:0] == OPCODE_SYSTEM);

	always_comb begin
		req_next = '0;
		req_next.index = i_instr[31:20];
		req_next.rd = i_instr[11:7];
		// Immediate forms carry the zero-extended rs1 field.
		req_next.operand = funct3[2] ? {27'd0, rs1_field} : i_rs1_value;

		if (is_system) begin
			case (funct3[1:0])
				2'b01: req_next.op = csr_pkg::OP_WRITE;
				2'b10: req_next.op = csr_pkg::OP_SET;
				2'b11: req_next.op = csr_pkg::OP_CLEAR;
				default: begin
					if (i_instr == INSTR_ECALL)
						req_next.op = csr_pkg::OP_ECALL;
					else if (i_instr == INSTR_MRET)
						req_next.op = csr_pkg::OP_MRET;
					else
						req_next.op = csr_pkg::OP_NONE;
				end
			endcase
		end

		req_next.valid = (req_next.op != csr_pkg::OP_NONE);
		// Set and clear with x0 or a zero immediate only read.
		req_next.write_en = (req_next.op == csr_pkg::OP_WRITE) ||
			(((req_next.op == csr_pkg::OP_SET) || (req_next.op == csr_pkg::OP_CLEAR)) &&
			(rs1_field != 5'd0));
	end

	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_req <= '0;
		else
			o_req <= req_next;
	end

endmodule

// File: csr_counters.sv
// ########################################
// Cycle, wall-time and retired-instruction counters.
// ########################################
`timescale 1ns/100ps

module csr_counters (
	input logic i_clock,
	input logic i_reset,
	input logic i_retire,
	output csr_pkg::csr_counts_t o_counts
);

	logic [63:0] cycle;
	logic [63:0] wall_time;
	logic [63:0] instret;
	logic [csr_pkg::TICK_WIDTH-1:0] tick_count;
	logic tick;

	// Last clock of a wall-time period.
	assign tick = (tick_count == csr_pkg::TICK_WIDTH'(csr_pkg::TICK_CLOCKS - 1));

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			cycle <= 64'd0;
			wall_time <= 64'd0;
			instret <= 64'd0;
			tick_count <= '0;
		end else begin
			cycle <= cycle + 64'd1;

			if (tick) begin
				tick_count <= '0;
				wall_time <= wall_time + 64'd1;
			end else begin
				tick_count <= tick_count + 1'b1;
			end

			if (i_retire)
				instret <= instret + 64'd1;
		end
	end

	assign o_counts.cycle = cycle;
	assign o_counts.wall_time = wall_time;
	assign o_counts.instret = instret;

endmodule

// File: csr_file.sv
// ########################################
// Machine CSR file stage with interrupt latch and trap entry.
// ########################################
`timescale 1ns/100ps

module csr_file (
	input logic i_clock,
	input logic i_reset,
	input csr_pkg::csr_req_t i_req,
	input csr_pkg::csr_counts_t i_counts,
	input logic i_timer_interrupt,
	input logic i_external_interrupt,
	input logic i_irq_dispatched,
	input logic [31:0] i_irq_epc,
	output csr_pkg::csr_result_t o_result,
	output logic [31:0] o_epc,
	output logic o_irq_pending,
	output logic [31:0] o_irq_pc
);

	logic mstatus_mie;
	logic mstatus_mpie;
	logic mie_meie;
	logic mie_mtie;
	logic mie_msie;
	logic mip_meip;
	logic mip_mtip;
	logic mip_msip;
	logic [31:0] mtvec;
	logic [31:0] mscratch;
	logic [31:0] mepc;
	logic [31:0] mcause;
	// One-hot issued source with external in the top bit.
	logic [2:0] issued;

	logic [31:0] mstatus;
	logic [31:0] mie;
	logic [31:0] mip;
	logic [31:0] rdata;
	logic [31:0] wdata;
	logic is_access;
	logic do_write;
	logic any_pending;

	assign mstatus = {24'd0, mstatus_mpie, 3'd0, mstatus_mie, 3'd0};
	assign mie = {20'd0, mie_meie, 3'd0, mie_mtie, 3'd0, mie_msie, 3'd0};
	assign mip = {20'd0, mip_meip, 3'd0, mip_mtip, 3'd0, mip_msip, 3'd0};

	assign is_access = i_req.valid && (i_req.op inside
		{csr_pkg::OP_WRITE, csr_pkg::OP_SET, csr_pkg::OP_CLEAR});
	assign do_write = is_access && i_req.write_en;
	assign any_pending = mip_meip || mip_mtip || mip_msip;
	assign o_epc = mepc;

	// Old value of the addressed CSR or zero when unknown.
	always_comb begin
		case (i_req.index)
			csr_pkg::CSR_MSTATUS: rdata = mstatus;
			csr_pkg::CSR_MIE: rdata = mie;
			csr_pkg::CSR_MTVEC: rdata = mtvec;
			csr_pkg::CSR_MSCRATCH: rdata = mscratch;
			csr_pkg::CSR_MEPC: rdata = mepc;
			csr_pkg::CSR_MCAUSE: rdata = mcause;
			csr_pkg::CSR_MIP: rdata = mip;
			csr_pkg::CSR_CYCLE: rdata = i_counts.cycle[31:0];
			csr_pkg::CSR_CYCLEH: rdata = i_counts.cycle[63:32];
			csr_pkg::CSR_TIME: rdata = i_counts.wall_time[31:0];
			csr_pkg::CSR_TIMEH: rdata = i_counts.wall_time[63:32];
			csr_pkg::CSR_INSTRET: rdata = i_counts.instret[31:0];
			csr_pkg::CSR_INSTRETH: rdata = i_counts.instret[63:32];
			csr_pkg::CSR_MVENDORID: rdata = csr_pkg::VENDOR_ID;
			csr_pkg::CSR_MARCHID: rdata = csr_pkg::ARCH_ID;
			csr_pkg::CSR_MIMPID: rdata = csr_pkg::IMP_ID;
			csr_pkg::CSR_MHARTID: rdata = csr_pkg::HART_ID;
			default: rdata = 32'd0;
		endcase
	end

	always_comb begin
		case (i_req.op)
			csr_pkg::OP_WRITE: wdata = i_req.operand;
			csr_pkg::OP_SET: wdata = rdata | i_req.operand;
			csr_pkg::OP_CLEAR: wdata = rdata & ~i_req.operand;
			default: wdata = rdata;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mstatus_mie <= 1'b0;
			mstatus_mpie <= 1'b0;
			mie_meie <= 1'b0;
			mie_mtie <= 1'b0;
			mie_msie <= 1'b0;
			mip_meip <= 1'b0;
			mip_mtip <= 1'b0;
			mip_msip <= 1'b0;
			mtvec <= 32'd0;
			mscratch <= 32'd0;
			mepc <= 32'd0;
			mcause <= 32'd0;
			issued <= 3'd0;
			o_irq_pending <= 1'b0;
			o_irq_pc <= 32'd0;
		end else begin
			if (do_write) begin
				case (i_req.index)
					csr_pkg::CSR_MSTATUS: begin
						mstatus_mpie <= wdata[7];
						mstatus_mie <= wdata[3];
					end
					csr_pkg::CSR_MIE: begin
						mie_meie <= wdata[11];
						mie_mtie <= wdata[7];
						mie_msie <= wdata[3];
					end
					csr_pkg::CSR_MIP: begin
						// External pending is owned by the input pin.
						mip_mtip <= wdata[7];
						mip_msip <= wdata[3];
					end
					csr_pkg::CSR_MTVEC: mtvec <= wdata;
					csr_pkg::CSR_MSCRATCH: mscratch <= wdata;
					csr_pkg::CSR_MEPC: mepc <= wdata;
					default: ;
				endcase
			end

			// Latch enabled sources.
			if (i_timer_interrupt && mie_mtie)
				mip_mtip <= 1'b1;
			if (i_external_interrupt && mie_meie)
				mip_meip <= 1'b1;
			if (i_req.valid && (i_req.op == csr_pkg::OP_ECALL) && mie_msie)
				mip_msip <= 1'b1;

			// Trap entry with the highest priority source first.
			if (!o_irq_pending && mstatus_mie && any_pending) begin
				if (mip_meip) begin
					mcause <= csr_pkg::CAUSE_EXTERNAL;
					issued <= 3'b100;
				end else if (mip_mtip) begin
					mcause <= csr_pkg::CAUSE_TIMER;
					issued <= 3'b010;
				end else begin
					mcause <= csr_pkg::CAUSE_SOFTWARE;
					issued <= 3'b001;
				end
				o_irq_pending <= 1'b1;
				o_irq_pc <= mtvec;
				mstatus_mpie <= mstatus_mie;
				mstatus_mie <= 1'b0;
			end

			if (i_req.valid && (i_req.op == csr_pkg::OP_MRET)) begin
				mstatus_mie <= mstatus_mpie;
				mstatus_mpie <= 1'b0;
			end

			// Core took the trap.
			if (i_irq_dispatched) begin
				mepc <= i_irq_epc;
				if (issued[2])
					mip_meip <= 1'b0;
				if (issued[1])
					mip_mtip <= 1'b0;
				if (issued[0])
					mip_msip <= 1'b0;
				issued <= 3'd0;
				o_irq_pending <= 1'b0;
			end
		end
	end

	// Result register.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_result <= '0;
		end else begin
			o_result.valid <= is_access;
			o_result.rd <= i_req.rd;
			o_result.rdata <= rdata;
		end
	end

endmodule

// File: csr_unit.sv
// ########################################
// CSR unit top: decode, CSR file, counters.
// ########################################
`timescale 1ns/100ps

module csr_unit (
	input logic i_clock,
	input logic i_reset,
	input logic i_instr_valid,
	input logic [31:0] i_instr,
	input logic [31:0] i_rs1_value,
	input logic i_retire,
	input logic i_timer_interrupt,
	input logic i_external_interrupt,
	input logic i_irq_dispatched,
	input logic [31:0] i_irq_epc,
	output csr_pkg::csr_result_t o_result,
	output logic [31:0] o_epc,
	output logic o_irq_pending,
	output logic [31:0] o_irq_pc
);

	csr_pkg::csr_req_t req;
	csr_pkg::csr_counts_t counts;

	csr_decode u_decode (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_instr_valid(i_instr_valid),
		.i_instr(i_instr),
		.i_rs1_value(i_rs1_value),
		.o_req(req)
	);

	csr_counters u_counters (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_retire(i_retire),
		.o_counts(counts)
	);

	csr_file u_file (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req(req),
		.i_counts(counts),
		.i_timer_interrupt(i_timer_interrupt),
		.i_external_interrupt(i_external_interrupt),
		.i_irq_dispatched(i_irq_dispatched),
		.i_irq_epc(i_irq_epc),
		.o_result(o_result),
		.o_epc(o_epc),
		.o_irq_pending(o_irq_pending),
		.o_irq_pc(o_irq_pc)
	);

endmodule

// File: csr_unit_tb.sv
// ########################################
// Testbench for the CSR unit with access table, interrupt and counter tests.
// ########################################
`timescale 1ns/100ps

module csr_unit_tb;

	localparam int RESET_CYCLES = 16;
	localparam logic [2:0] F_RW = 3'b001;
	localparam logic [2:0] F_RS = 3'b010;
	localparam logic [2:0] F_RC = 3'b011;
	localparam logic [2:0] F_RWI = 3'b101;
	localparam logic [2:0] F_RSI = 3'b110;
	localparam logic [2:0] F_RCI = 3'b111;
	localparam logic [31:0] INSTR_ECALL = 32'h0000_0073;
	localparam logic [31:0] INSTR_MRET = 32'h3020_0073;

	logic i_clock;
	logic i_reset;
	logic i_instr_valid;
	logic [31:0] i_instr;
	logic [31:0] i_rs1_value;
	logic i_retire;
	logic i_timer_interrupt;
	logic i_external_interrupt;
	logic i_irq_dispatched;
	logic [31:0] i_irq_epc;
	csr_pkg::csr_result_t o_result;
	logic [31:0] o_epc;
	logic o_irq_pending;
	logic [31:0] o_irq_pc;

	logic [31:0] rng_state;
	logic [31:0] table_instr[$];
	logic [31:0] table_rs1[$];
	csr_pkg::csr_result_t table_expect[$];
	// Reference copies of the writable machine registers.
	logic [31:0] model_mscratch;
	logic [31:0] model_mtvec;
	logic [31:0] model_mie;
	logic [31:0] model_mstatus;
	logic [31:0] model_mepc;
	int error_count;
	int check_count;
	int test_count;

	csr_unit uut (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_instr_valid(i_instr_valid),
		.i_instr(i_instr),
		.i_rs1_value(i_rs1_value),
		.i_retire(i_retire),
		.i_timer_interrupt(i_timer_interrupt),
		.i_external_interrupt(i_external_interrupt),
		.i_irq_dispatched(i_irq_dispatched),
		.i_irq_epc(i_irq_epc),
		.o_result(o_result),
		.o_epc(o_epc),
		.o_irq_pending(o_irq_pending),
		.o_irq_pc(o_irq_pc)
	);

	initial begin
		i_clock = 1'b0;
		forever #10 i_clock = ~i_clock;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	function automatic logic [31:0] encode_csr(input logic [2:0] funct3, input logic [11:0] addr,
		input logic [4:0] src, input logic [4:0] rd);
		return {addr, src, funct3, rd, 7'b1110011};
	endfunction

	function automatic logic [31:0] model_read(input logic [11:0] addr);
		case (addr)
			csr_pkg::CSR_MSTATUS: return model_mstatus;
			csr_pkg::CSR_MIE: return model_mie;
			csr_pkg::CSR_MTVEC: return model_mtvec;
			csr_pkg::CSR_MSCRATCH: return model_mscratch;
			csr_pkg::CSR_MEPC: return model_mepc;
			csr_pkg::CSR_MVENDORID: return csr_pkg::VENDOR_ID;
			csr_pkg::CSR_MARCHID: return csr_pkg::ARCH_ID;
			csr_pkg::CSR_MIMPID: return csr_pkg::IMP_ID;
			csr_pkg::CSR_MHARTID: return csr_pkg::HART_ID;
			default: return 32'd0;
		endcase
	endfunction

	// Only MIE/MPIE and the three enables are implemented.
	task automatic model_write(input logic [11:0] addr, input logic [31:0] value);
		case (addr)
			csr_pkg::CSR_MSTATUS: model_mstatus = value & 32'h0000_0088;
			csr_pkg::CSR_MIE: model_mie = value & 32'h0000_0888;
			csr_pkg::CSR_MTVEC: model_mtvec = value;
			csr_pkg::CSR_MSCRATCH: model_mscratch = value;
			csr_pkg::CSR_MEPC: model_mepc = value;
			default: ;
		endcase
	endtask

	task automatic add_access(input logic [2:0] funct3, input logic [11:0] addr,
		input logic [4:0] src, input logic [31:0] value);
		logic [31:0] operand;
		logic [31:0] old_value;
		logic [31:0] new_value;
		logic [4:0] rd;
		csr_pkg::csr_result_t expect_res;
		rd = 5'(table_instr.size() % 31 + 1);
		operand = funct3[2] ? {27'd0, src} : value;
		old_value = model_read(addr);
		case (funct3[1:0])
			2'b01: new_value = operand;
			2'b10: new_value = old_value | operand;
			default: new_value = old_value & ~operand;
		endcase
		// Set and clear with a zero source only read.
		if ((funct3[1:0] == 2'b01) || (src != 5'd0))
			model_write(addr, new_value);
		expect_res.valid = 1'b1;
		expect_res.rd = rd;
		expect_res.rdata = old_value;
		table_instr.push_back(encode_csr(funct3, addr, src, rd));
		table_rs1.push_back(value);
		table_expect.push_back(expect_res);
	endtask

	task automatic compare_result(input csr_pkg::csr_result_t got,
		input csr_pkg::csr_result_t expected, input string what);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("error at %0d ns: %s gave valid %b rd %0d rdata %h, expected %b %0d %h",
				$time, what, got.valid, got.rd, got.rdata,
				expected.valid, expected.rd, expected.rdata);
		end
	endtask

	task automatic compare_word(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("error at %0d ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before)
			$display("test %s: passed", name);
		else
			$display("test %s: failed with %0d errors", name, error_count - errors_before);
	endtask

	// Issues one instruction and samples its result two cycles later.
	task automatic run_instr(input logic [31:0] instr, input logic [31:0] rs1,
		output csr_pkg::csr_result_t res);
		@(posedge i_clock);
		i_instr_valid <= 1'b1;
		i_instr <= instr;
		i_rs1_value <= rs1;
		@(posedge i_clock);
		i_instr_valid <= 1'b0;
		@(posedge i_clock);
		@(negedge i_clock);
		res = o_result;
	endtask

	task automatic read_csr(input logic [11:0] addr, output logic [31:0] value);
		csr_pkg::csr_result_t res;
		run_instr(encode_csr(F_RS, addr, 5'd0, 5'd1), 32'd0, res);
		compare_word(32'(res.valid), 32'd1, "read result valid");
		value = res.rdata;
	endtask

	// Two reads of one CSR issued gap cycles apart.
	task automatic read_pair(input logic [11:0] addr, input int gap,
		output logic [31:0] first, output logic [31:0] second);
		for (int c = 0; c <= gap + 2; c++) begin
			@(posedge i_clock);
			i_instr_valid <= (c == 0) || (c == gap);
			i_instr <= encode_csr(F_RS, addr, 5'd0, 5'd2);
			i_rs1_value <= 32'd0;
			@(negedge i_clock);
			if (c == 2)
				first = o_result.rdata;
			if (c == gap + 2)
				second = o_result.rdata;
		end
	endtask

	task automatic wait_pending(input string what);
		for (int waited = 0; waited < 4; waited++) begin
			@(negedge i_clock);
			if (o_irq_pending)
				break;
		end
		check_count++;
		if (!o_irq_pending) begin
			error_count++;
			$display("The %s interrupt did not become pending within 4 cycles.", what);
		end
	endtask

	task automatic dispatch(input logic [31:0] epc);
		@(posedge i_clock);
		i_irq_dispatched <= 1'b1;
		i_irq_epc <= epc;
		@(posedge i_clock);
		i_irq_dispatched <= 1'b0;
		@(negedge i_clock);
		compare_word(o_epc, epc, "mepc after dispatch");
		compare_word(32'(o_irq_pending), 32'd0, "pending after dispatch");
	endtask

	task automatic build_table();
		// Write forms back to back.
		add_access(F_RW, csr_pkg::CSR_MSCRATCH, 5'd5, next_random());
		add_access(F_RWI, csr_pkg::CSR_MSCRATCH, 5'h15, 32'd0);
		add_access(F_RW, csr_pkg::CSR_MTVEC, 5'd6, next_random());
		add_access(F_RWI, csr_pkg::CSR_MTVEC, 5'h1c, 32'd0);
		add_access(F_RW, csr_pkg::CSR_MTVEC, 5'd7, next_random());
		add_access(F_RS, csr_pkg::CSR_MTVEC, 5'd0, 32'd0);
		add_access(F_RS, csr_pkg::CSR_MSCRATCH, 5'd8, next_random());
		add_access(F_RC, csr_pkg::CSR_MSCRATCH, 5'd9, next_random());
		add_access(F_RCI, csr_pkg::CSR_MSCRATCH, 5'd0, 32'd0);
		add_access(F_RSI, csr_pkg::CSR_MSCRATCH, 5'h1f, 32'd0);
		add_access(F_RS, csr_pkg::CSR_MSCRATCH, 5'd0, 32'd0);
		add_access(F_RW, csr_pkg::CSR_MEPC, 5'd17, next_random());
		add_access(F_RS, csr_pkg::CSR_MEPC, 5'd0, 32'd0);
		// Unimplemented bits read back as zero.
		add_access(F_RW, csr_pkg::CSR_MIE, 5'd10, 32'hffff_ffff);
		add_access(F_RC, csr_pkg::CSR_MIE, 5'd11, 32'hffff_ffff);
		add_access(F_RS, csr_pkg::CSR_MSTATUS, 5'd12, 32'hffff_ffff);
		add_access(F_RCI, csr_pkg::CSR_MSTATUS, 5'h1f, 32'd0);
		add_access(F_RC, csr_pkg::CSR_MSTATUS, 5'd13, 32'hffff_ffff);
		add_access(F_RW, 12'h7c0, 5'd14, next_random());
		add_access(F_RS, 12'h7c0, 5'd0, 32'd0);
		add_access(F_RW, csr_pkg::CSR_MVENDORID, 5'd15, next_random());
		add_access(F_RS, csr_pkg::CSR_MARCHID, 5'd16, next_random());
		add_access(F_RWI, csr_pkg::CSR_MIMPID, 5'h11, 32'd0);
		add_access(F_RS, csr_pkg::CSR_MHARTID, 5'd0, 32'd0);
		add_access(F_RS, csr_pkg::CSR_MVENDORID, 5'd0, 32'd0);
		add_access(F_RS, csr_pkg::CSR_MIMPID, 5'd0, 32'd0);
	endtask

	initial begin
		#1;
		repeat (RESET_CYCLES + table_instr.size() + 200) @(posedge i_clock);
		$display("The run timed out before all tests finished.");
		$display("Done: errors found");
		$finish;
	end

	initial begin
		csr_pkg::csr_result_t res;
		logic [31:0] tvec;
		logic [31:0] value;
		logic [31:0] first;
		logic [31:0] second;
		int errors_before;
		int retire_count;
		int gap;
		i_reset = 1'b1;
		i_instr_valid = 1'b0;
		i_instr = 32'd0;
		i_rs1_value = 32'd0;
		i_retire = 1'b0;
		i_timer_interrupt = 1'b0;
		i_external_interrupt = 1'b0;
		i_irq_dispatched = 1'b0;
		i_irq_epc = 32'd0;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		rng_state = 32'h7d42_29d0;
		model_mscratch = 32'd0;
		model_mtvec = 32'd0;
		model_mie = 32'd0;
		model_mstatus = 32'd0;
		model_mepc = 32'd0;
		build_table();
		repeat (RESET_CYCLES) @(posedge i_clock);
		i_reset <= 1'b0;

		// One entry per cycle with the result two cycles behind.
		errors_before = error_count;
		for (int k = 0; k < table_instr.size() + 2; k++) begin
			@(posedge i_clock);
			i_instr_valid <= (k < table_instr.size());
			if (k < table_instr.size()) begin
				i_instr <= table_instr[k];
				i_rs1_value <= table_rs1[k];
			end
			@(negedge i_clock);
			if (k >= 2)
				compare_result(o_result, table_expect[k - 2], $sformatf("table entry %0d", k - 2));
		end
		end_test("csr access table", errors_before);

		errors_before = error_count;
		tvec = next_random() & ~32'h3;
		run_instr(encode_csr(F_RW, csr_pkg::CSR_MTVEC, 5'd10, 5'd1), tvec, res);
		run_instr(encode_csr(F_RW, csr_pkg::CSR_MIE, 5'd11, 5'd1), 32'h0000_0888, res);
		run_instr(encode_csr(F_RSI, csr_pkg::CSR_MSTATUS, 5'd8, 5'd1), 32'd0, res);
		@(posedge i_clock);
		i_timer_interrupt <= 1'b1;
		i_external_interrupt <= 1'b1;
		wait_pending("external");
		compare_word(o_irq_pc, tvec, "trap pc");
		@(posedge i_clock);
		i_timer_interrupt <= 1'b0;
		i_external_interrupt <= 1'b0;
		read_csr(csr_pkg::CSR_MCAUSE, value);
		compare_word(value, csr_pkg::CAUSE_EXTERNAL, "mcause");
		read_csr(csr_pkg::CSR_MSTATUS, value);
		compare_word(value, 32'h0000_0080, "mstatus after trap entry");
		dispatch(next_random());
		// Timer stays latched until MRET opens MIE again.
		run_instr(INSTR_MRET, 32'd0, res);
		compare_word(32'(res.valid), 32'd0, "MRET result valid");
		wait_pending("timer");
		read_csr(csr_pkg::CSR_MCAUSE, value);
		compare_word(value, csr_pkg::CAUSE_TIMER, "mcause");
		dispatch(next_random());
		run_instr(INSTR_MRET, 32'd0, res);
		run_instr(INSTR_ECALL, 32'd0, res);
		compare_word(32'(res.valid), 32'd0, "ECALL result valid");
		wait_pending("software");
		read_csr(csr_pkg::CSR_MCAUSE, value);
		compare_word(value, csr_pkg::CAUSE_SOFTWARE, "mcause");
		dispatch(next_random());
		end_test("interrupts", errors_before);

		errors_before = error_count;
		retire_count = int'(next_random() % 8) + 4;
		repeat (retire_count) begin
			@(posedge i_clock);
			i_retire <= 1'b1;
			@(posedge i_clock);
			i_retire <= 1'b0;
		end
		read_csr(csr_pkg::CSR_INSTRET, value);
		compare_word(value, 32'(retire_count), "instret");
		gap = int'(next_random() % 5) + 2;
		read_pair(csr_pkg::CSR_CYCLE, gap, first, second);
		compare_word(second - first, 32'(gap), "cycle difference");
		read_pair(csr_pkg::CSR_TIME, 3 * csr_pkg::TICK_CLOCKS, first, second);
		// Three full ticks pass between the two reads.
		compare_word(second - first, 32'd3, "time difference");
		read_csr(csr_pkg::CSR_CYCLE, value);
		check_count++;
		if ((second < first) || (second > value / 32'(csr_pkg::TICK_CLOCKS))) begin
			error_count++;
			$display("error at %0d ns: time reads %h then %h do not fit cycle %h",
				$time, first, second, value);
		end
		end_test("counters", errors_before);

		$display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
		if (error_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: verilog.f
csr_pkg.sv
csr_decode.sv
csr_counters.sv
csr_file.sv
csr_unit.sv
csr_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the CSR unit testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f verilog.f --top-module csr_unit_tb \
	-o csr_unit_tb_sim > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }

./obj_dir/csr_unit_tb_sim > sim.log 2>&1

grep -qx "Done: no errors" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
